/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module execBackendTb -f all.f
	@out=$$(./obj_dir/VexecBackendTb); echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+design
design/backendPkg.sv
design/issueQueue.sv
design/physRegFile.sv
design/intAlu.sv
design/intMul.sv
design/wbControl.sv
design/execBackend.sv
tb/execBackendTb.sv

/* design/backendPkg.sv */
`include "backend_config.svh"

package backendPkg;

    typedef logic [`TAG_BITS-1:0] Tag;
    typedef logic [`SQN_BITS-1:0] SqN;
    typedef logic [`DATA_BITS-1:0] Data;

    typedef enum logic [0:0] {
        FU_ALU,
        FU_MUL
    } FuncUnit;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        MUL
    } AluOp;

    // Second operand word, register tag or full immediate
    typedef union packed {
        struct packed {
            logic [`DATA_BITS-`TAG_BITS-1:0] pad;
            Tag tag;
        } tagView;
        Data imm;
    } OperandB;

    typedef struct packed {
        Tag tagA;
        logic availA;
        OperandB srcB;
        logic immB;
        logic availB;
        Tag tagDst;
        SqN sqN;
        FuncUnit fu;
        AluOp opcode;
    } MicroOp;

    typedef struct packed {
        logic valid;
        MicroOp op;
    } DispatchSlot;

    // Operands already resolved, input of both units
    typedef struct packed {
        logic valid;
        Tag tagDst;
        SqN sqN;
        FuncUnit fu;
        AluOp opcode;
        Data valA;
        Data valB;
    } IssuedOp;

    typedef struct packed {
        logic valid;
        Tag tagDst;
        SqN sqN;
        Data data;
    } ResultBus;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchFlush;

    // True when a is older than b or the same op
    function automatic logic olderOrSame(SqN a, SqN b);
        logic signed [`SQN_BITS-1:0] diff;
        diff = a - b;
        return diff <= 0;
    endfunction

endpackage

/* design/backend_config.svh */
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// Issue queue depth and dispatch group size
`define IQ_SIZE 8
`define DISPATCH_WIDTH 2

// Tag 0 is the constant zero register
`define TAG_BITS 5

// Age compare relies on wrapped difference
`define SQN_BITS 6

`define DATA_BITS 32

// Supported range is 2 to 8
`define MUL_LAT 3

`endif

/* design/execBackend.sv */
`timescale 1ns/1ns
`include "backend_config.svh"

module execBackend (
    input  logic clk,
    input  logic rst,
    input  backendPkg::DispatchSlot dispatch[`DISPATCH_WIDTH],
    input  backendPkg::BranchFlush flush,
    output logic full,
    output backendPkg::ResultBus result
);

    backendPkg::DispatchSlot issued;
    backendPkg::Data dataA;
    backendPkg::Data dataB;
    backendPkg::IssuedOp exOp;
    backendPkg::ResultBus aluOut;
    backendPkg::ResultBus mulOut;
    logic aluBlocked;

    issueQueue queue (
        .clk(clk),
        .rst(rst),
        .dispatch(dispatch),
        .flush(flush),
        .result(result),
        .aluBlocked(aluBlocked),
        .issued(issued),
        .full(full)
    );

    physRegFile regFile (
        .clk(clk),
        .rst(rst),
        .tagA(issued.op.tagA),
        .tagB(issued.op.srcB.tagView.tag),
        .dataA(dataA),
        .dataB(dataB),
        .result(result)
    );

    // Operand B comes from the immediate view when immB is set
    always_comb begin
        exOp.valid = issued.valid;
        exOp.tagDst = issued.op.tagDst;
        exOp.sqN = issued.op.sqN;
        exOp.fu = issued.op.fu;
        exOp.opcode = issued.op.opcode;
        exOp.valA = dataA;
        exOp.valB = issued.op.immB ? issued.op.srcB.imm : dataB;
    end

    intAlu alu (
        .clk(clk),
        .rst(rst),
        .op(exOp),
        .flush(flush),
        .out(aluOut)
    );

    intMul mul (
        .clk(clk),
        .rst(rst),
        .op(exOp),
        .flush(flush),
        .out(mulOut)
    );

    wbControl wb (
        .clk(clk),
        .rst(rst),
        .issued(issued),
        .aluOut(aluOut),
        .mulOut(mulOut),
        .aluBlocked(aluBlocked),
        .result(result)
    );

endmodule

/* design/intAlu.sv */
`timescale 1ns/1ns

module intAlu (
    input  logic clk,
    input  logic rst,
    input  backendPkg::IssuedOp op,
    input  backendPkg::BranchFlush flush,
    output backendPkg::ResultBus out
);

    backendPkg::Data value;
    logic take;
    logic killed;

    logic outValid;
    backendPkg::Tag outTag;
    backendPkg::SqN outSqN;
    backendPkg::Data outData;

    always_comb begin
        case (op.opcode)
            backendPkg::ADD: value = op.valA + op.valB;
            backendPkg::SUB: value = op.valA - op.valB;
            backendPkg::AND: value = op.valA & op.valB;
            backendPkg::OR:  value = op.valA | op.valB;
            backendPkg::XOR: value = op.valA ^ op.valB;
            backendPkg::SLL: value = op.valA << op.valB[4:0];
            backendPkg::SRL: value = op.valA >> op.valB[4:0];
            default:         value = '0;
        endcase
    end

    // Drop an op younger than the resolving branch
    assign killed = flush.taken && !backendPkg::olderOrSame(op.sqN, flush.sqN);
    assign take = op.valid && op.fu == backendPkg::FU_ALU && !killed;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= take;
        end
    end

    always_ff @(posedge clk) begin
        outTag <= op.tagDst;
        outSqN <= op.sqN;
        outData <= value;
    end

    assign out.valid = outValid;
    assign out.tagDst = outTag;
    assign out.sqN = outSqN;
    assign out.data = outData;

endmodule

/* design/intMul.sv */
`timescale 1ns/1ns
`include "backend_config.svh"

module intMul (
    input  logic clk,
    input  logic rst,
    input  backendPkg::IssuedOp op,
    input  backendPkg::BranchFlush flush,
    output backendPkg::ResultBus out
);

    logic [`MUL_LAT-1:0] stageValid;
    backendPkg::Tag tagPipe[`MUL_LAT];
    backendPkg::SqN sqnPipe[`MUL_LAT];
    backendPkg::Data prodPipe[`MUL_LAT];

    function automatic logic survives(
        logic v,
        backendPkg::SqN s,
        backendPkg::BranchFlush f
    );
        return v && !(f.taken && !backendPkg::olderOrSame(s, f.sqN));
    endfunction

    // Every stage checks its own op against the flush
    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid[0] <= survives(op.valid && op.fu == backendPkg::FU_MUL, op.sqN, flush);
            for (int i = 1; i < `MUL_LAT; i++) begin
                stageValid[i] <= survives(stageValid[i-1], sqnPipe[i-1], flush);
            end
        end
    end

    // Low half of the product only
    always_ff @(posedge clk) begin
        tagPipe[0] <= op.tagDst;
        sqnPipe[0] <= op.sqN;
        prodPipe[0] <= op.valA * op.valB;
        for (int i = 1; i < `MUL_LAT; i++) begin
            tagPipe[i] <= tagPipe[i-1];
            sqnPipe[i] <= sqnPipe[i-1];
            prodPipe[i] <= prodPipe[i-1];
        end
    end

    assign out.valid = stageValid[`MUL_LAT-1];
    assign out.tagDst = tagPipe[`MUL_LAT-1];
    assign out.sqN = sqnPipe[`MUL_LAT-1];
    assign out.data = prodPipe[`MUL_LAT-1];

endmodule

/* design/issueQueue.sv */
`timescale 1ns/1ns
`include "backend_config.svh"

module issueQueue (
    input  logic clk,
    input  logic rst,
    input  backendPkg::DispatchSlot dispatch[`DISPATCH_WIDTH],
    input  backendPkg::BranchFlush flush,
    input  backendPkg::ResultBus result,
    input  logic aluBlocked,
    output backendPkg::DispatchSlot issued,
    output logic full
);

    localparam int IDX_W = $clog2(`IQ_SIZE);
    localparam int CNT_W = $clog2(`IQ_SIZE + 1);

    // Entry 0 is always the oldest
    backendPkg::MicroOp entries[`IQ_SIZE];
    backendPkg::MicroOp woke[`IQ_SIZE];
    backendPkg::MicroOp entriesNext[`IQ_SIZE];

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] countNext;
    logic [CNT_W-1:0] flushCount;
    logic [CNT_W:0] slotsValid;

    logic pickValid;
    logic [IDX_W-1:0] pickIdx;
    logic accept;

    logic issueValid;
    backendPkg::MicroOp issueOp;
    logic aluWake;

    function automatic backendPkg::MicroOp wakeUp(
        backendPkg::MicroOp u,
        logic resValid,
        backendPkg::Tag resTag,
        logic aluValid,
        backendPkg::Tag aluTag
    );
        backendPkg::MicroOp w;
        w = u;
        if ((resValid && u.tagA == resTag) || (aluValid && u.tagA == aluTag)) begin
            w.availA = 1'b1;
        end
        if (!u.immB && ((resValid && u.srcB.tagView.tag == resTag) ||
                        (aluValid && u.srcB.tagView.tag == aluTag))) begin
            w.availB = 1'b1;
        end
        return w;
    endfunction

    // An ALU op in the issue register writes back next cycle, so its
    // consumers can be picked now and take the value from the bypass
    assign aluWake = issueValid && issueOp.fu == backendPkg::FU_ALU;

    // Wake-up and oldest-ready select
    always_comb begin
        pickValid = 1'b0;
        pickIdx = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            woke[i] = wakeUp(entries[i], result.valid, result.tagDst, aluWake, issueOp.tagDst);
            if (!pickValid && CNT_W'(i) < count && woke[i].availA &&
                (woke[i].availB || woke[i].immB) &&
                !(aluBlocked && woke[i].fu == backendPkg::FU_ALU)) begin
                pickValid = 1'b1;
                pickIdx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        slotsValid = '0;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            slotsValid = slotsValid + (CNT_W + 1)'(dispatch[s].valid);
        end
        full = ({1'b0, count} + slotsValid) > (CNT_W + 1)'(`IQ_SIZE);
    end

    assign accept = !full && !flush.taken;

    // Keep the prefix of entries not younger than the branch
    always_comb begin
        flushCount = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            if (CNT_W'(i) < count && backendPkg::olderOrSame(entries[i].sqN, flush.sqN)) begin
                flushCount = CNT_W'(i + 1);
            end
        end
    end

    // Compaction behind the picked entry, then append the new group
    always_comb begin
        logic [CNT_W-1:0] ins;
        entriesNext = woke;
        ins = count;
        if (flush.taken) begin
            ins = flushCount;
        end else begin
            if (pickValid) begin
                for (int i = 0; i < `IQ_SIZE - 1; i++) begin
                    if (IDX_W'(i) >= pickIdx) begin
                        entriesNext[i] = woke[i + 1];
                    end
                end
                ins = count - 1'b1;
            end
            if (accept) begin
                for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
                    if (dispatch[s].valid) begin
                        entriesNext[ins[IDX_W-1:0]] = wakeUp(dispatch[s].op, result.valid,
                            result.tagDst, aluWake, issueOp.tagDst);
                        ins = ins + 1'b1;
                    end
                end
            end
        end
        countNext = ins;
    end

    always_ff @(posedge clk) begin
        entries <= entriesNext;
        if (pickValid) begin
            issueOp <= woke[pickIdx];
        end
    end

    // Nothing issues in a flush cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            issueValid <= 1'b0;
        end else begin
            count <= countNext;
            issueValid <= pickValid && !flush.taken;
        end
    end

    assign issued.valid = issueValid;
    assign issued.op = issueOp;

endmodule

/* design/physRegFile.sv */
`timescale 1ns/1ns
`include "backend_config.svh"

module physRegFile (
    input  logic clk,
    input  logic rst,
    input  backendPkg::Tag tagA,
    input  backendPkg::Tag tagB,
    output backendPkg::Data dataA,
    output backendPkg::Data dataB,
    input  backendPkg::ResultBus result
);

    localparam int NUM_REGS = 1 << `TAG_BITS;

    backendPkg::Data regs[NUM_REGS];
    logic hitA;
    logic hitB;

    // Bypass the value being written this cycle
    assign hitA = result.valid && result.tagDst == tagA;
    assign hitB = result.valid && result.tagDst == tagB;

    assign dataA = (tagA == '0) ? '0 : (hitA ? result.data : regs[tagA]);
    assign dataB = (tagB == '0) ? '0 : (hitB ? result.data : regs[tagB]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (result.valid && result.tagDst != '0) begin
            regs[result.tagDst] <= result.data;
        end
    end

endmodule

/* design/wbControl.sv */
`timescale 1ns/1ns
`include "backend_config.svh"

module wbControl (
    input  logic clk,
    input  logic rst,
    input  backendPkg::DispatchSlot issued,
    input  backendPkg::ResultBus aluOut,
    input  backendPkg::ResultBus mulOut,
    output logic aluBlocked,
    output backendPkg::ResultBus result
);

    // Bit i set when a multiplier result lands i cycles from now
    logic [`MUL_LAT-1:0] resv;
    logic [`MUL_LAT:0] busy;
    logic mulIssue;

    assign mulIssue = issued.valid && issued.op.fu == backendPkg::FU_MUL;

    // The op now in the issue register adds its landing slot
    assign busy = {mulIssue, resv};

    // An ALU op picked this cycle writes back two cycles from now
    assign aluBlocked = busy[2];

    always_ff @(posedge clk) begin
        if (rst) begin
            resv <= '0;
        end else begin
            resv <= busy[`MUL_LAT:1];
        end
    end

    // Reserved slot belongs to the multiplier
    assign result = resv[0] ? mulOut : aluOut;

endmodule

/* tb/execBackendTb.sv */
`timescale 1ns/1ns
`include "backend_config.svh"

module execBackendTb;

    localparam int NUM_TAGS = 1 << `TAG_BITS;
    localparam int NUM_OPS = 200;
    localparam int CHAIN_OPS = 40;
    localparam int CYCLE_LIMIT = 2 * NUM_OPS * (`MUL_LAT + 2) + 200;

    logic clk;
    logic rst;
    backendPkg::DispatchSlot dispatch[`DISPATCH_WIDTH];
    backendPkg::BranchFlush flush;
    logic full;
    backendPkg::ResultBus result;

    // Shadow register file and per-tag bookkeeping
    backendPkg::Data shadow[NUM_TAGS];
    logic busy[NUM_TAGS];
    logic written[NUM_TAGS];
    int readers[NUM_TAGS];
    backendPkg::MicroOp pendOp[NUM_TAGS];
    int acceptCycle[NUM_TAGS];
    int expLat[NUM_TAGS];

    backendPkg::DispatchSlot group[`DISPATCH_WIDTH];
    logic holding;
    logic chainMode;
    logic fullSeen;
    backendPkg::SqN nextSqN;
    backendPkg::Tag lastDst;
    int seed;
    int cycle;
    int lastFlushCycle;
    int errors;
    int checks;
    int dispatched;
    int results;
    int flushes;
    int killedOps;
    int timedChecks;

    execBackend uut (
        .clk(clk),
        .rst(rst),
        .dispatch(dispatch),
        .flush(flush),
        .full(full),
        .result(result)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        if (cycle > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d ops outstanding", cycle, outstanding());
            $display("Verification failed");
            $finish;
        end
    end

    // Positive wrapped difference means a is younger
    function automatic logic isYounger(backendPkg::SqN a, backendPkg::SqN b);
        logic signed [`SQN_BITS-1:0] d;
        d = a - b;
        return d > 0;
    endfunction

    function automatic backendPkg::Data applyOp(backendPkg::AluOp op, backendPkg::Data a,
                                                backendPkg::Data b);
        case (op)
            backendPkg::ADD: return a + b;
            backendPkg::SUB: return a - b;
            backendPkg::AND: return a & b;
            backendPkg::OR:  return a | b;
            backendPkg::XOR: return a ^ b;
            backendPkg::SLL: return a << b[4:0];
            backendPkg::SRL: return a >> b[4:0];
            backendPkg::MUL: return a * b;
            default:         return '0;
        endcase
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (busy[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    // Sequence distance to the oldest op in flight
    function automatic int oldestAge();
        backendPkg::SqN d;
        int age;
        age = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            d = nextSqN - pendOp[t].sqN;
            if (busy[t] && int'(d) > age) begin
                age = int'(d);
            end
        end
        return age;
    endfunction

    function automatic logic usable(int t);
        return t == 0 || busy[t] || written[t];
    endfunction

    function automatic backendPkg::Tag pickSource();
        int t;
        if ((chainMode || $random(seed) % 2 == 0) && usable(lastDst)) begin
            return lastDst;
        end
        for (int k = 0; k < 8; k++) begin
            t = {$random(seed)} % NUM_TAGS;
            if (usable(t)) begin
                return backendPkg::Tag'(t);
            end
        end
        return '0;
    endfunction

    function automatic logic inGroup(int t, int upto);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            if (group[k].op.tagA == t) begin
                hit = 1'b1;
            end
            if (!group[k].op.immB && group[k].op.srcB.tagView.tag == t) begin
                hit = 1'b1;
            end
            if (k < upto && group[k].valid && group[k].op.tagDst == t) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Free means no result pending and no reader left in flight
    function automatic backendPkg::Tag pickDest(int upto);
        int r;
        int t;
        r = {$random(seed)} % (NUM_TAGS - 1);
        for (int k = 0; k < NUM_TAGS - 1; k++) begin
            t = 1 + (r + k) % (NUM_TAGS - 1);
            if (!busy[t] && readers[t] == 0 && !inGroup(t, upto)) begin
                return backendPkg::Tag'(t);
            end
        end
        return '0;
    endfunction

    task automatic claimSlot(int s, backendPkg::Tag d);
        group[s].valid = 1'b1;
        group[s].op.tagDst = d;
        group[s].op.sqN = nextSqN;
        nextSqN++;
        lastDst = d;
        holding = 1'b1;
    endtask

    task automatic makeGroup();
        backendPkg::Tag d;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            group[s] = '0;
            group[s].op.tagA = pickSource();
            group[s].op.immB = chainMode || ($random(seed) % 3 == 0);
            if (group[s].op.immB) begin
                group[s].op.srcB.imm = $random(seed);
            end else begin
                group[s].op.srcB.tagView.tag = pickSource();
            end
            if (chainMode || $random(seed) % 3 == 0) begin
                group[s].op.fu = backendPkg::FU_MUL;
                group[s].op.opcode = backendPkg::MUL;
            end else begin
                group[s].op.fu = backendPkg::FU_ALU;
                group[s].op.opcode = backendPkg::AluOp'({$random(seed)} % 7);
            end
        end
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            d = pickDest(s);
            if (d != '0 && (s == 0 || $random(seed) % 4 != 0)) begin
                claimSlot(s, d);
            end
        end
    endtask

    // Availability follows the shadow state on every cycle a group is held
    task automatic driveCycle(logic mayFlush, int target);
        int t;
        flush = '0;
        if (!holding && dispatched < target && oldestAge() < 24) begin
            makeGroup();
        end
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            dispatch[s] = holding ? group[s] : '0;
            dispatch[s].op.availA = !busy[dispatch[s].op.tagA];
            dispatch[s].op.availB = !dispatch[s].op.immB &&
                                    !busy[dispatch[s].op.srcB.tagView.tag];
        end
        if (mayFlush && $random(seed) % 20 == 0) begin
            t = {$random(seed)} % NUM_TAGS;
            if (busy[t]) begin
                flush.taken = 1'b1;
                flush.sqN = pendOp[t].sqN;
            end
        end
    endtask

    task automatic dropReaders(backendPkg::MicroOp u);
        readers[u.tagA]--;
        if (!u.immB) begin
            readers[u.srcB.tagView.tag]--;
        end
    endtask

    task automatic checkResult();
        backendPkg::MicroOp u;
        backendPkg::Data a;
        backendPkg::Data b;
        backendPkg::Data want;
        int t;
        if (result.valid) begin
            t = result.tagDst;
            results++;
            checks++;
            assert (busy[t] && pendOp[t].sqN == result.sqN) else begin
                errors++;
                $display("Result for tag %0d sqN %0d has no accepted op in flight",
                         t, result.sqN);
            end
            if (busy[t]) begin
                u = pendOp[t];
                a = shadow[u.tagA];
                b = u.immB ? u.srcB.imm : shadow[u.srcB.tagView.tag];
                want = applyOp(u.opcode, a, b);
                checks += 2;
                assert (!busy[u.tagA] && (u.immB || !busy[u.srcB.tagView.tag])) else begin
                    errors++;
                    $display("Result for tag %0d came before one of its source results", t);
                end
                assert (result.data == want) else begin
                    errors++;
                    $display("[ERROR] result data, tag %0d %s: expected %h, actual %h",
                             t, u.opcode.name(), want, result.data);
                end
                if (expLat[t] != 0) begin
                    timedChecks++;
                    assert (cycle - acceptCycle[t] == expLat[t]) else begin
                        errors++;
                        $display("[ERROR] latency, tag %0d: expected %0d, actual %0d",
                                 t, expLat[t], cycle - acceptCycle[t]);
                    end
                end
                shadow[t] = want;
                busy[t] = 1'b0;
                written[t] = 1'b1;
                dropReaders(u);
            end
        end
    endtask

    task automatic noteAccept();
        logic idle;
        int t;
        idle = outstanding() == 0 && cycle - lastFlushCycle > `MUL_LAT + 2;
        if (holding && !full && !flush.taken) begin
            for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
                if (dispatch[s].valid) begin
                    t = dispatch[s].op.tagDst;
                    busy[t] = 1'b1;
                    pendOp[t] = dispatch[s].op;
                    // Group enters the queue at the next rising edge
                    acceptCycle[t] = cycle + 1;
                    expLat[t] = 0;
                    readers[dispatch[s].op.tagA]++;
                    if (!dispatch[s].op.immB) begin
                        readers[dispatch[s].op.srcB.tagView.tag]++;
                    end
                    // Only the head op of an idle backend has a fixed latency
                    if (s == 0 && idle && dispatch[s].op.availA &&
                        (dispatch[s].op.immB || dispatch[s].op.availB)) begin
                        expLat[t] = (dispatch[s].op.fu == backendPkg::FU_MUL) ?
                                    `MUL_LAT + 1 : 2;
                    end
                    dispatched++;
                end
            end
            holding = 1'b0;
        end
    endtask

    task automatic applyFlush();
        flushes++;
        lastFlushCycle = cycle;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (busy[t] && isYounger(pendOp[t].sqN, flush.sqN)) begin
                busy[t] = 1'b0;
                dropReaders(pendOp[t]);
                killedOps++;
            end
        end
        holding = 1'b0;
    endtask

    // Checks and bookkeeping in mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            checkResult();
            noteAccept();
            if (flush.taken) begin
                applyFlush();
            end
            if (full) begin
                fullSeen = 1'b1;
            end
        end
    end

    task automatic runUntil(int target, logic mayFlush);
        while (dispatched < target || holding) begin
            @(posedge clk);
            #10;
            driveCycle(mayFlush, target);
        end
    endtask

    task automatic sendSingle(backendPkg::FuncUnit fu, backendPkg::AluOp opc);
        @(posedge clk);
        #10;
        group[0] = '0;
        group[1] = '0;
        group[0].op.tagA = lastDst;
        group[0].op.immB = 1'b1;
        group[0].op.srcB.imm = $random(seed);
        group[0].op.fu = fu;
        group[0].op.opcode = opc;
        claimSlot(0, pickDest(0));
        driveCycle(1'b0, 0);
        while (holding || outstanding() > 0) begin
            @(posedge clk);
            #10;
            driveCycle(1'b0, 0);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        seed = 43430;
        flush = '0;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            dispatch[s] = '0;
            group[s] = '0;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            shadow[t] = '0;
            busy[t] = 1'b0;
            written[t] = (t == 0);
            readers[t] = 0;
            pendOp[t] = '0;
            acceptCycle[t] = 0;
            expLat[t] = 0;
        end
        holding = 1'b0;
        chainMode = 1'b0;
        fullSeen = 1'b0;
        nextSqN = '0;
        lastDst = '0;
        cycle = 0;
        lastFlushCycle = -100;
        errors = 0;
        checks = 0;
        dispatched = 0;
        results = 0;
        flushes = 0;
        killedOps = 0;
        timedChecks = 0;

        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        @(negedge clk);
        checks++;
        assert (!full) else begin
            errors++;
            $display("full is high right after reset");
        end

        sendSingle(backendPkg::FU_ALU, backendPkg::ADD);
        sendSingle(backendPkg::FU_MUL, backendPkg::MUL);

        // Dependent multiplier chains to fill the queue
        chainMode = 1'b1;
        runUntil(dispatched + CHAIN_OPS, 1'b0);
        chainMode = 1'b0;
        runUntil(NUM_OPS, 1'b1);

        while (outstanding() > 0) begin
            @(posedge clk);
            #10;
            driveCycle(1'b0, 0);
        end
        repeat (`MUL_LAT + 4) begin
            @(posedge clk);
            #10;
            driveCycle(1'b0, 0);
        end

        checks += 4;
        assert (fullSeen) else begin
            errors++;
            $display("full never went high during the multiplier chains");
        end
        assert (timedChecks >= 2) else begin
            errors++;
            $display("Latency was never measured on an idle backend");
        end
        assert (flushes > 0) else begin
            errors++;
            $display("No branch flush was applied");
        end
        assert (results + killedOps == dispatched) else begin
            errors++;
            $display("[ERROR] result count: expected %0d, actual %0d",
                     dispatched - killedOps, results);
        end

        $display("Checks %0d, errors %0d, ops %0d, results %0d, flushes %0d, flushed ops %0d",
                 checks, errors, dispatched, results, flushes, killedOps);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
